// ==== Bender.yml ====
package:
  name: xadc_readout

sources:
  - xadc_pkg.sv
  - xadc_sequencer.sv
  - xadc_sample_ctrl.sv
  - xadc_packer.sv
  - xadc_fifo_writer.sv
  - xadc_readout_top.sv
  - target: simulation
    files:
      - tb_xadc_readout.sv

// ==== filelist.f ====
xadc_pkg.sv
xadc_sequencer.sv
xadc_sample_ctrl.sv
xadc_packer.sv
xadc_fifo_writer.sv
xadc_readout_top.sv
tb_xadc_readout.sv

// ==== tb_xadc_readout.sv ====
module tb_xadc_readout;
    import xadc_pkg::*;

    localparam int max_words_tb = 4;
    localparam int rst_cycles   = 10;

    // Run limit of samples * (delay + 12) + 50 per test
    localparam int t_single  = 7 * (0 + 12) + 50;
    localparam int t_fill    = 10 * (0 + 12) + 50;
    localparam int t_all     = 24 * (0 + 12) + 50;
    localparam int t_limit   = 25 * (0 + 12) + 50;
    localparam int t_delay   = 4 * (20 + 12) + 50;
    localparam int t_hold    = 2 * (0 + 12) + 50;
    localparam int timeout_cycles = rst_cycles + t_single + t_fill + t_all + t_limit +
                                    t_delay + t_hold;

    logic                  clk125 = 1'b0;
    logic                  rst;
    logic                  data_in_rdy;
    logic [vmm_id_w-1:0]   vmm_id;
    logic [count_w-1:0]    sample_size;
    logic [delay_w-1:0]    delay_in;
    logic                  udp_done;
    logic                  adc_done;
    logic [sample_w-1:0]   adc_result;
    logic [chip_w:0]       mux_addr;
    logic                  mux_addr3_n;
    logic                  adc_start;
    logic                  fifo_wr;
    logic [word_w-1:0]     fifo_data;
    logic [len_w-1:0]      packet_len;
    logic                  end_of_data;
    logic                  xadc_busy;

    logic [word_w-1:0] wr_data[$];  // Collected FIFO writes
    logic [len_w-1:0]  wr_len[$];
    logic              wr_eod[$];

    int unsigned adc_lat[256];  // ADC latencies drawn once
    int          lat;
    int          lat_idx = 0;
    int          sample_num;    // Running sample number in each test
    int          cycle = 0;
    int          last_done_cyc;
    int          min_gap;
    int          mux3_bad;
    int          errors;
    int          checks;

    always #4 clk125 = ~clk125;

    xadc_readout_top #(
        .max_words (max_words_tb)
    ) uut
    (
        .clk125      (clk125),
        .rst         (rst),
        .data_in_rdy (data_in_rdy),
        .vmm_id      (vmm_id),
        .sample_size (sample_size),
        .delay_in    (delay_in),
        .udp_done    (udp_done),
        .adc_done    (adc_done),
        .adc_result  (adc_result),
        .mux_addr    (mux_addr),
        .mux_addr3_n (mux_addr3_n),
        .adc_start   (adc_start),
        .fifo_wr     (fifo_wr),
        .fifo_data   (fifo_data),
        .packet_len  (packet_len),
        .end_of_data (end_of_data),
        .xadc_busy   (xadc_busy)
    );

    ////////////////////
    // ADC model
    ////////////////////

    always
    begin
        @(posedge clk125);
        if (adc_start === 1'b1)
        begin
            lat = adc_lat[lat_idx % 256];  // 2 to 9 cycles
            lat_idx++;
            repeat (lat - 1) @(posedge clk125);
            #1;
            adc_result = {mux_addr, sample_num[7:0]};
            adc_done   = 1'b1;
            sample_num++;
            @(posedge clk125);
            #1;
            adc_done = 1'b0;
        end
    end

    // FIFO monitor, start gap tracking and watchdog
    always @(posedge clk125)
    begin
        if (!rst)
        begin
            if (fifo_wr)
            begin
                wr_data.push_back(fifo_data);
                wr_len.push_back(packet_len);
                wr_eod.push_back(end_of_data);
            end
            if (mux_addr3_n !== 1'b1)
                mux3_bad++;
            if (adc_start && (last_done_cyc >= 0) && (cycle - last_done_cyc < min_gap))
                min_gap = cycle - last_done_cyc;
            if (adc_done)
                last_done_cyc = cycle;
        end
        cycle++;
        if (cycle >= timeout_cycles)
        begin
            $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
            $display("Closing count: %0d checks, %0d errors", checks, errors + 1);
            $display("Simulation failed");
            $finish;
        end
    end

    ////////////////////
    // Helpers
    ////////////////////

    task automatic next_cycle();
        @(posedge clk125);
        #1;
    endtask

    task automatic check_val(input string name, input string what,
                             input logic [63:0] exp, input logic [63:0] got);
        checks++;
        assert (got === exp)
        else
        begin
            $display("CHECK FAILED %s %s: expected %h, actual %h", name, what, exp, got);
            errors++;
        end
    endtask

    // Result as the ADC model builds it
    function automatic logic [sample_w-1:0] sample_value(input int chip, input int num);
        sample_value = {1'b0, chip[2:0], num[7:0]};
    endfunction

    // Walks the words of one chip, five results each, short last word
    task automatic check_chip(input string name, input int chip, input int first_num,
                              input int n_samples, inout int idx);
        int              left;
        int              num;
        int              n;
        int              cnt;
        logic [63:0]     exp_word;
        logic            exp_eod;
        left = n_samples;
        num  = first_num;
        cnt  = 0;
        while (left > 0)
        begin
            n        = (left > slots_per_word) ? slots_per_word : left;
            exp_word = '0;
            exp_word[63:60] = {1'b0, chip[2:0]};
            for (int k = 0; k < n; k++)
                exp_word[12 * k +: 12] = sample_value(chip, num + k);
            left -= n;
            num  += n;
            cnt++;
            exp_eod = (left == 0) || (cnt == max_words_tb);
            assert (idx < wr_data.size())
            else
            begin
                $display("%s: word %0d of chip %0d never reached the FIFO", name, idx, chip);
                errors++;
            end
            if (idx >= wr_data.size())
                return;
            check_val(name, "fifo_data", exp_word, wr_data[idx]);
            check_val(name, "packet_len", cnt, wr_len[idx]);
            check_val(name, "end_of_data", exp_eod, wr_eod[idx]);
            if (exp_eod)
                cnt = 0;  // Count restarts after a closed frame
            idx++;
        end
    endtask

    // Request, handshake and wait for busy to drop
    task automatic run_request(input string name, input int id, input int size,
                               input int delay, input int hold);
        int exp_words;
        next_cycle();
        wr_data.delete();
        wr_len.delete();
        wr_eod.delete();
        sample_num    = 0;
        mux3_bad      = 0;
        last_done_cyc = -1;
        min_gap       = 1 << 30;
        vmm_id        = id[3:0];
        sample_size   = size[10:0];
        delay_in      = delay[17:0];
        udp_done      = 1'b0;
        data_in_rdy   = 1'b1;
        next_cycle();
        while (!xadc_busy)
            next_cycle();
        data_in_rdy = 1'b0;
        if (hold > 0)
        begin
            exp_words = (size + slots_per_word - 1) / slots_per_word;
            while (wr_data.size() < exp_words)
                next_cycle();
            repeat (hold) next_cycle();
            check_val(name, "xadc_busy while udp_done low", 1, xadc_busy);
        end
        udp_done = 1'b1;
        while (xadc_busy)
            next_cycle();
        repeat (3) next_cycle();
        // Save is one cycle after adc_done, then delay_in + 1 cycles of gap
        if (min_gap < (1 << 30))
        begin
            checks++;
            assert (min_gap >= delay + 2)
            else
            begin
                $display("CHECK FAILED %s adc_start gap: expected >= %0d, actual %0d",
                         name, delay + 2, min_gap);
                errors++;
            end
        end
    endtask

    ////////////////////
    // Tests
    ////////////////////

    task automatic test_single_chip();
        int idx;
        idx = 0;
        run_request("single_chip", 3, 7, 0, 0);
        check_chip("single_chip", 2, 0, 7, idx);
        check_val("single_chip", "word count", 2, wr_data.size());
    endtask

    task automatic test_exact_fill();
        int idx;
        idx = 0;
        run_request("exact_fill", 1, 10, 0, 0);
        check_chip("exact_fill", 0, 0, 10, idx);
        check_val("exact_fill", "word count", 2, wr_data.size());  // No empty third word
    endtask

    task automatic test_all_chips();
        int idx;
        idx = 0;
        run_request("all_chips", 0, 3, 0, 0);
        for (int c = 0; c < num_chips; c++)
            check_chip("all_chips", c, c * 3, 3, idx);
        check_val("all_chips", "word count", 8, wr_data.size());
        check_val("all_chips", "mux_addr3_n low cycles", 0, mux3_bad);
    endtask

    task automatic test_word_limit();
        int idx;
        idx = 0;
        run_request("word_limit", 5, 25, 0, 0);
        check_chip("word_limit", 4, 0, 25, idx);
        check_val("word_limit", "word count", 5, wr_data.size());
    endtask

    task automatic test_delay();
        int idx;
        idx = 0;
        run_request("delay", 8, 4, 20, 0);
        check_chip("delay", 7, 0, 4, idx);
        check_val("delay", "word count", 1, wr_data.size());
    endtask

    task automatic test_busy_hold();
        int idx;
        idx = 0;
        run_request("busy_hold", 2, 2, 0, 20);
        check_chip("busy_hold", 1, 0, 2, idx);
        check_val("busy_hold", "word count", 1, wr_data.size());
    endtask

    initial
    begin
        void'($urandom(72458));
        for (int i = 0; i < 256; i++)
            adc_lat[i] = 2 + ($urandom % 8);
        rst           = 1'b1;
        data_in_rdy   = 1'b0;
        vmm_id        = '0;
        sample_size   = '0;
        delay_in      = '0;
        udp_done      = 1'b0;
        adc_done      = 1'b0;
        adc_result    = '0;
        errors        = 0;
        checks        = 0;
        sample_num    = 0;
        mux3_bad      = 0;
        last_done_cyc = -1;
        min_gap       = 1 << 30;
        repeat (rst_cycles) @(posedge clk125);
        #1;
        rst = 1'b0;

        test_single_chip();
        test_exact_fill();
        test_all_chips();
        test_word_limit();
        test_delay();
        test_busy_hold();

        $display("Closing count: %0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

// ==== xadc_fifo_writer.sv ====
module xadc_fifo_writer
#(
    parameter int max_words = xadc_pkg::default_max_words
)
(
    input  logic                        clk125,
    input  logic                        rst,
    input  logic                        word_valid,
    input  logic [xadc_pkg::word_w-1:0] word,
    input  logic                        word_last,
    output logic                        fifo_wr,
    output logic [xadc_pkg::word_w-1:0] fifo_data,
    output logic [xadc_pkg::len_w-1:0]  packet_len,
    output logic                        end_of_data,
    output logic                        frame_done
);
    import xadc_pkg::*;

    logic [len_w-1:0] frame_cnt;  // Words already written in this frame
    logic [len_w-1:0] next_len;
    logic             at_limit;
    logic             close;

    assign next_len = frame_cnt + 1'b1;
    assign at_limit = (next_len == len_w'(max_words));

    // Either the chip is done or the frame is full
    assign close = word_last || at_limit;

    ////////////////////
    // FIFO write
    ////////////////////

    always_ff @(posedge clk125)
    begin
        if (rst)
        begin
            fifo_wr     <= 1'b0;
            end_of_data <= 1'b0;
            frame_done  <= 1'b0;
            frame_cnt   <= '0;
            packet_len  <= '0;
        end
        else
        begin
            fifo_wr     <= word_valid;
            end_of_data <= word_valid && close;
            frame_done  <= word_valid && word_last;  // Not on the size limit
            if (word_valid)
            begin
                packet_len <= next_len;  // Counts this word too
                if (close)
                    frame_cnt <= '0;
                else
                    frame_cnt <= next_len;
            end
        end
    end

    always_ff @(posedge clk125)
    begin
        if (word_valid)
            fifo_data <= word;
    end

endmodule

// ==== xadc_packer.sv ====
module xadc_packer
(
    input  logic                          clk125,
    input  logic                          rst,
    input  logic                          save,
    input  logic [xadc_pkg::sample_w-1:0] result,
    input  logic [xadc_pkg::chip_w-1:0]   chip,
    input  logic                          last,
    output logic                          word_valid,
    output logic [xadc_pkg::word_w-1:0]   word,
    output logic                          word_last
);
    import xadc_pkg::*;

    localparam int idx_w     = $clog2(slots_per_word);
    localparam int payload_w = slots_per_word * sample_w;

    localparam logic [idx_w-1:0] top_slot = idx_w'(slots_per_word - 1);

    logic [payload_w-1:0] slots;       // Results gathered so far
    logic [payload_w-1:0] slots_next;
    logic [idx_w-1:0]     slot_idx;    // Next free slot
    logic [header_w-1:0]  header;
    logic                 emit;

    // Full word or end of chip
    assign emit = save && (last || (slot_idx == top_slot));

    assign header = {1'b0, chip};

    always_comb
    begin
        slots_next = slots;
        slots_next[slot_idx * sample_w +: sample_w] = result;
    end

    ////////////////////
    // Slot filling
    ////////////////////

    always_ff @(posedge clk125)
    begin
        if (rst)
        begin
            slots      <= '0;
            slot_idx   <= '0;
            word_valid <= 1'b0;
        end
        else
        begin
            word_valid <= emit;
            if (save)
            begin
                if (emit)
                begin
                    slots    <= '0;  // Unused slots of the next word read as zero
                    slot_idx <= '0;
                end
                else
                begin
                    slots    <= slots_next;
                    slot_idx <= slot_idx + 1'b1;
                end
            end
        end
    end

    // Finished word with its chip header
    always_ff @(posedge clk125)
    begin
        if (emit)
        begin
            word      <= {header, slots_next};
            word_last <= last;
        end
    end

endmodule

// ==== xadc_pkg.sv ====
package xadc_pkg;

    ////////////////////
    // Data widths
    ////////////////////

    localparam int sample_w = 12;  // One ADC result
    localparam int chip_w   = 3;   // Chip index 0 to 7
    localparam int header_w = 4;   // Zero in bit 3, chip index below
    localparam int word_w   = 64;  // FIFO word

    // Five results per word, slot k at bits 12k+11 down to 12k
    // Header sits on top at bits 63 to 60
    localparam int slots_per_word = 5;

    ////////////////////
    // Request fields
    ////////////////////

    localparam int count_w  = 11;  // Samples per chip
    localparam int delay_w  = 18;  // Idle gap between samples
    localparam int len_w    = 12;  // Words in the current frame
    localparam int vmm_id_w = 4;   // Requested chip, 1 to 8

    localparam int num_chips = 8;

    // Frame length limit, overridable from the top level
    localparam int default_max_words = 150;

endpackage

// ==== xadc_readout_top.sv ====
module xadc_readout_top
#(
    parameter int max_words = xadc_pkg::default_max_words
)
(
    input  logic                          clk125,
    input  logic                          rst,
    input  logic                          data_in_rdy,
    input  logic [xadc_pkg::vmm_id_w-1:0] vmm_id,
    input  logic [xadc_pkg::count_w-1:0]  sample_size,
    input  logic [xadc_pkg::delay_w-1:0]  delay_in,
    input  logic                          udp_done,
    input  logic                          adc_done,
    input  logic [xadc_pkg::sample_w-1:0] adc_result,
    output logic [xadc_pkg::chip_w:0]     mux_addr,
    output logic                          mux_addr3_n,
    output logic                          adc_start,
    output logic                          fifo_wr,
    output logic [xadc_pkg::word_w-1:0]   fifo_data,
    output logic [xadc_pkg::len_w-1:0]    packet_len,
    output logic                          end_of_data,
    output logic                          xadc_busy
);
    import xadc_pkg::*;

    // Sequencer to sample controller
    logic              sample_req;
    logic [chip_w-1:0] req_chip;
    logic              req_last;

    // Sample controller to packer
    logic                save;
    logic [sample_w-1:0] save_result;
    logic [chip_w-1:0]   save_chip;
    logic                save_last;

    // Packer to writer, writer back to sequencer
    logic              word_valid;
    logic [word_w-1:0] word;
    logic              word_last;
    logic              frame_done;

    xadc_sequencer u_sequencer
    (
        .clk125      (clk125),
        .rst         (rst),
        .data_in_rdy (data_in_rdy),
        .vmm_id      (vmm_id),
        .sample_size (sample_size),
        .delay_in    (delay_in),
        .udp_done    (udp_done),
        .frame_done  (frame_done),
        .save        (save),
        .sample_req  (sample_req),
        .chip        (req_chip),
        .last        (req_last),
        .xadc_busy   (xadc_busy)
    );

    xadc_sample_ctrl u_sample_ctrl
    (
        .clk125      (clk125),
        .rst         (rst),
        .sample_req  (sample_req),
        .chip        (req_chip),
        .last        (req_last),
        .adc_done    (adc_done),
        .adc_result  (adc_result),
        .mux_addr    (mux_addr),
        .mux_addr3_n (mux_addr3_n),
        .adc_start   (adc_start),
        .save        (save),
        .result      (save_result),
        .chip_out    (save_chip),
        .last_out    (save_last)
    );

    xadc_packer u_packer
    (
        .clk125     (clk125),
        .rst        (rst),
        .save       (save),
        .result     (save_result),
        .chip       (save_chip),
        .last       (save_last),
        .word_valid (word_valid),
        .word       (word),
        .word_last  (word_last)
    );

    xadc_fifo_writer #(
        .max_words (max_words)
    ) u_fifo_writer
    (
        .clk125      (clk125),
        .rst         (rst),
        .word_valid  (word_valid),
        .word        (word),
        .word_last   (word_last),
        .fifo_wr     (fifo_wr),
        .fifo_data   (fifo_data),
        .packet_len  (packet_len),
        .end_of_data (end_of_data),
        .frame_done  (frame_done)
    );

endmodule

// ==== xadc_sample_ctrl.sv ====
module xadc_sample_ctrl
(
    input  logic                          clk125,
    input  logic                          rst,
    input  logic                          sample_req,
    input  logic [xadc_pkg::chip_w-1:0]   chip,
    input  logic                          last,
    input  logic                          adc_done,
    input  logic [xadc_pkg::sample_w-1:0] adc_result,
    output logic [xadc_pkg::chip_w:0]     mux_addr,
    output logic                          mux_addr3_n,
    output logic                          adc_start,
    output logic                          save,
    output logic [xadc_pkg::sample_w-1:0] result,
    output logic [xadc_pkg::chip_w-1:0]   chip_out,
    output logic                          last_out
);
    import xadc_pkg::*;

    logic pending;    // Conversion in flight
    logic last_hold;
    logic capture;

    assign capture     = pending && adc_done;
    assign mux_addr3_n = ~mux_addr[chip_w];  // Bit 3 is always low here

    always_ff @(posedge clk125)
    begin
        if (rst)
        begin
            mux_addr  <= '0;
            adc_start <= 1'b0;
            save      <= 1'b0;
            pending   <= 1'b0;
        end
        else
        begin
            adc_start <= sample_req;
            save      <= capture;
            if (sample_req)
            begin
                mux_addr <= {1'b0, chip};
                pending  <= 1'b1;
            end
            else if (adc_done)
                pending <= 1'b0;
        end
    end

    // Result and its tags
    always_ff @(posedge clk125)
    begin
        if (sample_req)
            last_hold <= last;
        if (capture)
        begin
            result   <= adc_result;
            chip_out <= mux_addr[chip_w-1:0];  // Mux still points at the sampled chip
            last_out <= last_hold;
        end
    end

endmodule

// ==== xadc_sequencer.sv ====
module xadc_sequencer
(
    input  logic                          clk125,
    input  logic                          rst,
    input  logic                          data_in_rdy,
    input  logic [xadc_pkg::vmm_id_w-1:0] vmm_id,
    input  logic [xadc_pkg::count_w-1:0]  sample_size,
    input  logic [xadc_pkg::delay_w-1:0]  delay_in,
    input  logic                          udp_done,
    input  logic                          frame_done,
    input  logic                          save,
    output logic                          sample_req,
    output logic [xadc_pkg::chip_w-1:0]   chip,
    output logic                          last,
    output logic                          xadc_busy
);
    import xadc_pkg::*;

    localparam logic [2:0] st_idle       = 3'd0;
    localparam logic [2:0] st_start      = 3'd1;
    localparam logic [2:0] st_wait_save  = 3'd2;
    localparam logic [2:0] st_delay      = 3'd3;
    localparam logic [2:0] st_wait_frame = 3'd4;
    localparam logic [2:0] st_release    = 3'd5;

    localparam logic [chip_w-1:0] last_chip = chip_w'(num_chips - 1);

    logic [2:0]         state;
    logic               all_mode;   // Sweep all eight chips
    logic [count_w-1:0] req_cnt;    // Requests issued for this chip
    logic [delay_w-1:0] delay_cnt;
    logic               sel_all;
    logic               final_req;
    logic               issue;
    logic               release_ok;

    // 1 to 8 picks one chip, anything else sweeps them all
    assign sel_all = (vmm_id == '0) || (vmm_id > num_chips);

    // A sample size of zero behaves as one
    assign final_req = (req_cnt + 1'b1) >= sample_size;

    assign issue = (state == st_start) ||
                   ((state == st_delay) && (delay_cnt == delay_in));

    // Old request gone and the UDP frame sent
    assign release_ok = !data_in_rdy && udp_done;

    ////////////////////
    // Sweep FSM
    ////////////////////

    always_ff @(posedge clk125)
    begin
        if (rst)
        begin
            state      <= st_idle;
            all_mode   <= 1'b0;
            chip       <= '0;
            last       <= 1'b0;
            req_cnt    <= '0;
            delay_cnt  <= '0;
            sample_req <= 1'b0;
            xadc_busy  <= 1'b0;
        end
        else
        begin
            sample_req <= 1'b0;

            if (issue)
            begin
                sample_req <= 1'b1;
                last       <= final_req;  // Flags the chip's final sample
                req_cnt    <= req_cnt + 1'b1;
                state      <= st_wait_save;
            end
            else
            begin
                case (state)
                    st_idle:
                    begin
                        if (data_in_rdy)
                        begin
                            xadc_busy <= 1'b1;
                            all_mode  <= sel_all;
                            chip      <= sel_all ? '0 : chip_w'(vmm_id - 1'b1);
                            req_cnt   <= '0;
                            state     <= st_start;
                        end
                    end

                    st_wait_save:
                    begin
                        if (save)
                        begin
                            delay_cnt <= '0;
                            state     <= last ? st_wait_frame : st_delay;
                        end
                    end

                    st_delay:
                        delay_cnt <= delay_cnt + 1'b1;

                    st_wait_frame:
                    begin
                        if (frame_done)
                        begin
                            req_cnt <= '0;
                            if (all_mode && (chip != last_chip))
                            begin
                                chip  <= chip + 1'b1;  // Next chip in the sweep
                                state <= st_start;
                            end
                            else if (release_ok)
                            begin
                                xadc_busy <= 1'b0;
                                state     <= st_idle;
                            end
                            else
                                state <= st_release;
                        end
                    end

                    st_release:
                    begin
                        if (release_ok)
                        begin
                            xadc_busy <= 1'b0;
                            state     <= st_idle;
                        end
                    end

                    default:
                        state <= st_idle;
                endcase
            end
        end
    end

endmodule
